// ==== verification/alu_queue_testdata.txt ====
// Columns in hex: phase (1 paced, 2 burst), op (0 add, 1 sub, 2 mul, 3 xor),
// operand a, operand b, expected 32-bit result
1 0 0001 0002 00000003
1 1 0010 0003 0000000D
1 2 0003 0004 0000000C
1 3 00FF 0F0F 00000FF0
1 0 FFFF FFFF 0001FFFE
1 1 0000 0001 FFFFFFFF
1 2 FFFF FFFF FFFE0001
1 3 FFFF 0000 0000FFFF
1 0 1234 4321 00005555
1 1 1234 4321 FFFFCF13
1 2 0100 0100 00010000
1 3 AAAA 5555 0000FFFF
1 0 8000 8000 00010000
1 1 8000 7FFF 00000001
1 2 1000 0010 00010000
1 3 1234 1234 00000000
2 0 0001 0100 00000101
2 1 0002 0001 00000001
2 2 0003 0003 00000009
2 3 0004 00F0 000000F4
2 0 0005 0100 00000105
2 1 0006 0007 FFFFFFFF
2 2 0007 0010 00000070
2 3 0008 00F0 000000F8
2 0 0009 0100 00000109
2 1 000A 0001 00000009
2 2 000B 0002 00000016
2 3 000C 00F0 000000FC
2 0 000D 0100 0000010D
2 1 000E 0010 FFFFFFFE
2 2 000F 000F 000000E1
2 3 0010 00F0 000000E0
2 0 0011 0100 00000111
2 1 0012 0002 00000010

// ==== vlog.f ====
common/queue_pkg.sv
src/fifo.sv
src/req_ingress.sv
src/alu_engine.sv
src/resp_egress.sv
src/alu_queue_top.sv
verification/alu_queue_checker.sv
verification/alu_queue_tb.sv

// ==== Makefile ====
# Verilator build and run for the arithmetic request queue

SIM = obj_dir/alu_queue_sim
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module alu_queue_tb \
		-f vlog.f -Mdir obj_dir -o alu_queue_sim

run: compile
	./$(SIM) | tee $(LOG)
	@if grep -q "^NO ERRORS$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== verification/alu_queue_tb.sv ====
/*
  Testbench top for the arithmetic request queue. Reads requests and expected
  results from the testdata file, runs a paced phase and then a burst.
*/
`timescale 1ns/1ps

module alu_queue_tb;

  import queue_pkg::*;

  localparam int MAX_LINES = 64;
  localparam int FIELDS    = 5;
  localparam int GAP_MAX   = 3;
  localparam int QUIET     = 4 * RESP_GAP;

  // DUT ports
  logic        clk;
  logic        rst;
  logic        req_valid;
  alu_op_e     req_op;
  operand_t    req_a;
  operand_t    req_b;
  logic        resp_valid;
  result_t     resp_data;
  drop_count_t drop_count;

  // Checker links
  logic        exp_push;
  logic        exp_burst;
  result_t     exp_data;
  logic        final_check;
  int          resp_count;
  int          error_count;

  // Test data, five words per line
  logic [31:0] tdata [MAX_LINES*FIELDS];
  int          n_paced;
  int          n_burst;
  int          timeout_limit = 0;
  int          cycle_cnt     = 0;
  int          quiet_cnt     = 0;
  int          gap;
  int          i;
  integer      seed;

  alu_queue_top UUT (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_op     (req_op),
    .req_a      (req_a),
    .req_b      (req_b),
    .resp_valid (resp_valid),
    .resp_data  (resp_data),
    .drop_count (drop_count)
  );

  alu_queue_checker u_checker (
    .clk         (clk),
    .rst         (rst),
    .resp_valid  (resp_valid),
    .resp_data   (resp_data),
    .drop_count  (drop_count),
    .exp_push    (exp_push),
    .exp_burst   (exp_burst),
    .exp_data    (exp_data),
    .final_check (final_check),
    .resp_count  (resp_count),
    .error_count (error_count)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // --------------------
  // Cycle count, quiet window and timeout
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    quiet_cnt <= resp_valid ? 0 : quiet_cnt + 1;
    if (timeout_limit > 0 && cycle_cnt >= timeout_limit) begin
      $display("Timeout: test did not finish within %0d cycles", timeout_limit);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // One request strobe, fields and expected value taken from a data line
  task automatic send_request(input int line);
    int base;
    base = line * FIELDS;
    @(negedge clk);
    req_valid = 1'b1;
    req_op    = alu_op_e'(tdata[base+1][1:0]);
    req_a     = tdata[base+2][15:0];
    req_b     = tdata[base+3][15:0];
    exp_push  = 1'b1;
    exp_burst = (tdata[base] == 32'd2);
    exp_data  = tdata[base+4];
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      req_valid = 1'b0;
      exp_push  = 1'b0;
    end
  endtask

  // --------------------
  // Main sequence
  initial begin
    rst         = 1'b1;
    req_valid   = 1'b0;
    req_op      = OP_ADD;
    req_a       = '0;
    req_b       = '0;
    exp_push    = 1'b0;
    exp_burst   = 1'b0;
    exp_data    = '0;
    final_check = 1'b0;
    n_paced     = 0;
    n_burst     = 0;
    seed        = 76;

    // Phase 0 marks unused lines
    for (i = 0; i < MAX_LINES * FIELDS; i++)
      tdata[i] = '0;
    $readmemh("verification/alu_queue_testdata.txt", tdata);
    for (i = 0; i < MAX_LINES; i++) begin
      if (tdata[i*FIELDS] == 32'd1)
        n_paced++;
      else if (tdata[i*FIELDS] == 32'd2)
        n_burst++;
    end
    if (n_paced == 0 || n_burst <= REQ_DEPTH + RESP_DEPTH + 2) begin
      $display("Test data missing or too short: %0d paced, %0d burst requests",
               n_paced, n_burst);
      $display("ERRORS FOUND");
      $finish;
    end
    timeout_limit = (n_paced + n_burst + 4) * 2 * RESP_GAP * 2 +
                    (n_paced + n_burst) * GAP_MAX;

    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Paced phase, slow enough that nothing is dropped
    for (i = 0; i < MAX_LINES; i++) begin
      if (tdata[i*FIELDS] == 32'd1) begin
        send_request(i);
        gap = $unsigned($random(seed)) % (GAP_MAX + 1);
        idle_cycles(2 * RESP_GAP - 1 + gap);
      end
    end
    while (resp_count < n_paced)
      @(negedge clk);
    idle_cycles(2 * RESP_GAP);

    // Burst phase, back to back
    for (i = 0; i < MAX_LINES; i++) begin
      if (tdata[i*FIELDS] == 32'd2)
        send_request(i);
    end
    idle_cycles(1);
    while (quiet_cnt < QUIET)
      @(negedge clk);

    @(negedge clk);
    final_check = 1'b1;
    @(negedge clk);
    final_check = 1'b0;

    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== verification/alu_queue_checker.sv ====
/*
  Scoreboard for the queue testbench. Takes each expected result as the bench
  sends its request, then checks reset state, values, order, pacing and drops.
*/
`timescale 1ns/1ps

module alu_queue_checker (
  input  logic                   clk,
  input  logic                   rst,
  // DUT outputs under watch
  input  logic                   resp_valid,
  input  queue_pkg::result_t     resp_data,
  input  queue_pkg::drop_count_t drop_count,
  // Expected result of each request, strobed with the request itself
  input  logic                   exp_push,
  input  logic                   exp_burst,
  input  queue_pkg::result_t     exp_data,
  // Run is quiet, time for the closing checks
  input  logic                   final_check,
  output int                     resp_count,
  output int                     error_count
);

  import queue_pkg::*;

  result_t     paced_q[$];
  result_t     burst_exp[$];
  result_t     exp_v;
  int          value_errs = 0;
  int          other_errs = 0;
  int          n_resp     = 0;
  int          paced_resp = 0;
  int          burst_resp = 0;
  int          burst_idx  = 0;
  int          cyc        = 0;
  int          last_resp  = 0;
  int          k;
  logic        resp_seen  = 1'b0;
  logic        rst_q      = 1'b0;
  logic        burst_on   = 1'b0;
  drop_count_t drop_base  = '0;

  assign resp_count  = n_resp;
  assign error_count = value_errs + other_errs;

  task automatic value_error(input string test, input logic [31:0] exp_w,
                             input logic [31:0] act_w);
    $display("Error %s: expected 0x%h, actual 0x%h", test, exp_w, act_w);
    value_errs++;
  endtask

  always @(posedge clk) begin
    cyc++;
    rst_q <= rst;

    // --------------------
    // Reset state, one edge into reset and one edge after it
    if (rst_q) begin
      if (resp_valid !== 1'b0)
        value_error("reset_valid", 32'd0, 32'(resp_valid));
      if (drop_count !== '0)
        value_error("reset_drops", 32'd0, 32'(drop_count));
    end

    // Expected results in send order
    if (!rst && exp_push) begin
      if (exp_burst) begin
        if (!burst_on) begin
          // Paced phase is over here, it must not have dropped anything
          burst_on  = 1'b1;
          drop_base = drop_count;
          if (drop_count != '0)
            value_error("paced_drops", 32'd0, 32'(drop_count));
        end
        burst_exp.push_back(exp_data);
      end else begin
        paced_q.push_back(exp_data);
      end
    end

    // --------------------
    // Responses
    if (!rst && resp_valid) begin
      if (resp_seen && (cyc - last_resp < RESP_GAP)) begin
        $display("Error pacing: expected gap of at least %0d cycles, actual %0d",
                 RESP_GAP, cyc - last_resp);
        value_errs++;
      end
      resp_seen = 1'b1;
      last_resp = cyc;
      n_resp++;

      if (paced_q.size() > 0) begin
        exp_v = paced_q.pop_front();
        if (resp_data !== exp_v)
          value_error($sformatf("paced_ops #%0d", paced_resp), exp_v, resp_data);
        paced_resp++;
      end else if (burst_on && burst_resp < REQ_DEPTH) begin
        // Head of the burst is never dropped, so exact match
        if (burst_resp >= burst_exp.size()) begin
          $display("Burst response %0d arrived before its request was sent", burst_resp);
          other_errs++;
        end else if (resp_data !== burst_exp[burst_resp]) begin
          value_error($sformatf("burst_head #%0d", burst_resp),
                      burst_exp[burst_resp], resp_data);
        end
        burst_idx = burst_resp + 1;
        burst_resp++;
      end else if (burst_on) begin
        // Rest of the burst, any in-order subsequence
        k = burst_idx;
        while (k < burst_exp.size() && burst_exp[k] !== resp_data)
          k++;
        if (k >= burst_exp.size()) begin
          $display("Error burst_order: expected a value from item %0d on, actual 0x%h",
                   burst_idx, resp_data);
          value_errs++;
        end else begin
          burst_idx = k + 1;
        end
        burst_resp++;
      end else begin
        $display("Response 0x%h arrived with no request outstanding", resp_data);
        other_errs++;
      end
    end

    // --------------------
    // Closing checks
    if (final_check) begin
      if (paced_q.size() != 0) begin
        $display("%0d paced responses never arrived", paced_q.size());
        other_errs++;
      end
      if (drop_count == drop_base) begin
        $display("Error burst_drops: expected more than 0, actual 0");
        value_errs++;
      end
      if (burst_resp + int'(drop_count - drop_base) != burst_exp.size())
        value_error("burst_balance", 32'(burst_exp.size()),
                    32'(burst_resp + int'(drop_count - drop_base)));
      $display("Checker: %0d errors (%0d value, %0d other), %0d responses, %0d drops",
               value_errs + other_errs, value_errs, other_errs, n_resp, drop_count);
    end
  end

endmodule

// ==== src/alu_queue_top.sv ====
/*
  Top level of the arithmetic request queue, ingress to engine to egress.
  Requests come in as strobes and results leave in acceptance order.
*/
`timescale 1ns/1ps

module alu_queue_top (
  input  logic                   clk,
  input  logic                   rst,
  // Request strobe and fields
  input  logic                   req_valid,
  input  queue_pkg::alu_op_e     req_op,
  input  queue_pkg::operand_t    req_a,
  input  queue_pkg::operand_t    req_b,
  // Paced result strobe
  output logic                   resp_valid,
  output queue_pkg::result_t     resp_data,
  // Requests lost to a full input FIFO
  output queue_pkg::drop_count_t drop_count
);

  // --------------------
  // Internal links
  queue_pkg::req_word_t req_word;
  logic                 req_empty;
  logic                 req_pop;
  logic                 res_push;
  queue_pkg::result_t   res_data;
  logic                 res_drain;

  // Input buffering and drop count
  req_ingress u_ingress (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_op     (req_op),
    .req_a      (req_a),
    .req_b      (req_b),
    .req_pop    (req_pop),
    .req_word   (req_word),
    .req_empty  (req_empty),
    .drop_count (drop_count)
  );

  // Credit based ALU pipeline
  alu_engine u_engine (
    .clk       (clk),
    .rst       (rst),
    .req_word  (req_word),
    .req_empty (req_empty),
    .req_pop   (req_pop),
    .res_drain (res_drain),
    .res_push  (res_push),
    .res_data  (res_data)
  );

  // Result buffering and pacing
  resp_egress u_egress (
    .clk        (clk),
    .rst        (rst),
    .res_push   (res_push),
    .res_data   (res_data),
    .res_drain  (res_drain),
    .resp_valid (resp_valid),
    .resp_data  (resp_data)
  );

endmodule

// ==== src/resp_egress.sv ====
/*
  Output side of the queue. Results wait in the result FIFO and leave as
  single cycle strobes, at least RESP_GAP cycles apart.
*/
`timescale 1ns/1ps

module resp_egress (
  input  logic               clk,
  input  logic               rst,
  // From the engine
  input  logic               res_push,
  input  queue_pkg::result_t res_data,
  output logic               res_drain,
  // To the consumer
  output logic               resp_valid,
  output queue_pkg::result_t resp_data
);

  import queue_pkg::*;

  logic             res_empty;
  result_t          head;
  logic [GAP_W-1:0] gap_cnt;
  logic             gap_done;

  // --------------------
  // Result FIFO
  // Engine credits keep pushes away from a full FIFO
  fifo #(
    .entry_t (result_t),
    .DEPTH   (RESP_DEPTH)
  ) u_res_fifo (
    .clk   (clk),
    .rst   (rst),
    .push  (res_push),
    .pop   (res_drain),
    .wdata (res_data),
    .empty (res_empty),
    .full  (),
    .rdata (head)
  );

  // --------------------
  // Pacing
  // Zero means expired, reload counts the release cycle itself
  assign gap_done  = (gap_cnt == '0);
  assign res_drain = !res_empty && gap_done;

  always_ff @(posedge clk) begin
    if (rst) begin
      gap_cnt <= '0;
    end else if (res_drain) begin
      gap_cnt <= GAP_W'(RESP_GAP - 1);
    end else if (!gap_done) begin
      gap_cnt <= gap_cnt - 1'b1;
    end
  end

  // --------------------
  // Output register
  always_ff @(posedge clk) begin
    if (rst) begin
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= res_drain;
    end
  end

  // Data holds between strobes
  always_ff @(posedge clk) begin
    if (res_drain) begin
      resp_data <= head;
    end
  end

endmodule

// ==== src/alu_engine.sv ====
/*
  Two stage ALU between the request and result FIFOs. Pops whenever a request
  is waiting and a result slot is free, result appears two cycles after pop.
*/
`timescale 1ns/1ps

module alu_engine (
  input  logic                 clk,
  input  logic                 rst,
  // Request FIFO head, read data is combinational
  input  queue_pkg::req_word_t req_word,
  input  logic                 req_empty,
  output logic                 req_pop,
  // Result FIFO, drain returns one credit
  input  logic                 res_drain,
  output logic                 res_push,
  output queue_pkg::result_t   res_data
);

  import queue_pkg::*;

  credit_t  credits;
  logic     s1_valid;
  alu_op_e  s1_op;
  operand_t s1_a;
  operand_t s1_b;
  result_t  alu_res;
  result_t  ext_a;
  result_t  ext_b;

  // --------------------
  // Pop and credits
  // Each credit stands for one free result FIFO slot
  assign req_pop = !req_empty && (credits != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      credits <= credit_t'(RESP_DEPTH);
    end else begin
      case ({req_pop, res_drain})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // --------------------
  // Stage 1, capture head at the pop edge
  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= req_pop;
    end
  end

  always_ff @(posedge clk) begin
    if (req_pop) begin
      s1_op <= alu_op_e'(req_word[OP_LSB +: OP_W]);
      s1_a  <= req_word[A_LSB +: OPND_W];
      s1_b  <= req_word[B_LSB +: OPND_W];
    end
  end

  // --------------------
  // Stage 2, compute and register
  assign ext_a = result_t'(s1_a);
  assign ext_b = result_t'(s1_b);

  always_comb begin
    case (s1_op)
      OP_ADD:  alu_res = ext_a + ext_b;
      // Wraps modulo 2^32 when b exceeds a
      OP_SUB:  alu_res = ext_a - ext_b;
      // 16x16 product fits the result word exactly
      OP_MUL:  alu_res = ext_a * ext_b;
      default: alu_res = ext_a ^ ext_b;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      res_push <= 1'b0;
    end else begin
      res_push <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      res_data <= alu_res;
    end
  end

endmodule

// ==== src/req_ingress.sv ====
/*
  Input side of the queue. Request strobes are packed and pushed into the
  request FIFO, requests that meet a full FIFO are dropped and counted.
*/
`timescale 1ns/1ps

module req_ingress (
  input  logic                  clk,
  input  logic                  rst,
  // Producer side, strobe qualifies the fields in the same cycle
  input  logic                  req_valid,
  input  queue_pkg::alu_op_e    req_op,
  input  queue_pkg::operand_t   req_a,
  input  queue_pkg::operand_t   req_b,
  // Engine side
  input  logic                  req_pop,
  output queue_pkg::req_word_t  req_word,
  output logic                  req_empty,
  // Overload status
  output queue_pkg::drop_count_t drop_count
);

  import queue_pkg::*;

  req_word_t in_word;
  logic      req_full;
  logic      accept;
  logic      drop;

  // --------------------
  // Accept or drop
  // Field order must match the slices in the engine
  assign in_word = {req_op, req_a, req_b};

  // No back-pressure, so a full FIFO loses the request
  assign accept = req_valid && !req_full;
  assign drop   = req_valid && req_full;

  fifo #(
    .entry_t (req_word_t),
    .DEPTH   (REQ_DEPTH)
  ) u_req_fifo (
    .clk   (clk),
    .rst   (rst),
    .push  (accept),
    .pop   (req_pop),
    .wdata (in_word),
    .empty (req_empty),
    .full  (req_full),
    .rdata (req_word)
  );

  // --------------------
  // Drop counter
  // Saturates at all ones instead of wrapping
  always_ff @(posedge clk) begin
    if (rst) begin
      drop_count <= '0;
    end else if (drop && (drop_count != '1)) begin
      drop_count <= drop_count + 1'b1;
    end
  end

endmodule

// ==== src/fifo.sv ====
/*
  Pointer based FIFO for any entry type, DEPTH must be a power of two.
  Read data shows the head entry combinationally while not empty.
*/
`timescale 1ns/1ps

module fifo #(
  parameter type entry_t = logic [31:0],
  parameter int  DEPTH   = 8
) (
  input  logic   clk,
  input  logic   rst,
  input  logic   push,
  input  logic   pop,
  input  entry_t wdata,
  output logic   empty,
  output logic   full,
  output entry_t rdata
);

  localparam int ADDR_W = $clog2(DEPTH);

  // Extra top bit tells a wrapped writer from an equal reader
  logic [ADDR_W:0] wptr;
  logic [ADDR_W:0] rptr;

  // --------------------
  // Pointers
  always_ff @(posedge clk) begin
    if (rst) begin
      wptr <= '0;
      rptr <= '0;
    end else begin
      if (push) begin
        wptr <= wptr + 1'b1;
      end
      if (pop) begin
        rptr <= rptr + 1'b1;
      end
    end
  end

  assign empty = (wptr == rptr);

  // --------------------
  // Storage and flags
  generate
    if (DEPTH == 1) begin : g_single
      entry_t slot;

      // Single slot, any pointer difference means full
      assign full = (wptr != rptr);

      always_ff @(posedge clk) begin
        if (rst) begin
          slot <= '0;
        end else if (push) begin
          slot <= wdata;
        end
      end

      assign rdata = slot;
    end else begin : g_array
      entry_t mem [DEPTH];

      // Same slot, different lap
      assign full = (wptr[ADDR_W-1:0] == rptr[ADDR_W-1:0]) &&
                    (wptr[ADDR_W] != rptr[ADDR_W]);

      always_ff @(posedge clk) begin
        if (rst) begin
          mem <= '{default: '0};
        end else if (push) begin
          mem[wptr[ADDR_W-1:0]] <= wdata;
        end
      end

      // Head entry
      assign rdata = mem[rptr[ADDR_W-1:0]];
    end
  endgenerate

endmodule

// ==== common/queue_pkg.sv ====
/*
  Shared widths, operation codes and depths for the arithmetic request queue.
  Modules import this package inside their bodies and use scoped names in port lists.
*/
package queue_pkg;

  // --------------------
  // Data widths
  localparam int OPND_W = 16;
  localparam int RES_W  = 32;
  localparam int OP_W   = 2;

  // Request word layout, op on top then a then b
  localparam int REQ_W  = OP_W + 2 * OPND_W;
  localparam int B_LSB  = 0;
  localparam int A_LSB  = B_LSB + OPND_W;
  localparam int OP_LSB = A_LSB + OPND_W;

  // --------------------
  // Queue sizing and pacing
  localparam int REQ_DEPTH  = 8;
  localparam int RESP_DEPTH = 4;
  localparam int RESP_GAP   = 4;

  // Counter widths, each wide enough to hold its full value
  localparam int CREDIT_W = $clog2(RESP_DEPTH + 1);
  localparam int GAP_W    = $clog2(RESP_GAP + 1);
  localparam int DROP_W   = 16;

  // --------------------
  // Types
  typedef logic [OPND_W-1:0]   operand_t;
  typedef logic [RES_W-1:0]    result_t;
  typedef logic [REQ_W-1:0]    req_word_t;
  typedef logic [DROP_W-1:0]   drop_count_t;
  typedef logic [CREDIT_W-1:0] credit_t;

  // ALU operation select
  typedef enum logic [OP_W-1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_MUL = 2'd2,
    OP_XOR = 2'd3
  } alu_op_e;

endpackage
